// File: build.f
rtl/cu_sizes_pkg.sv
rtl/cu_types_pkg.sv
rtl/cmd_fifo.sv
rtl/read_cmd_arbiter.sv
rtl/response_router.sv
rtl/cu_config_regs.sv
rtl/cu_control_top.sv
verification/cu_control_properties.sv
verification/cu_control_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the compute-unit control testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module cu_control_tb \
	-o cu_control_sim > build.log 2>&1 || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/cu_control_sim > sim.log 2>&1
cat sim.log

grep -q "tests failed" sim.log && { echo "FAIL"; exit 1; } || \
	grep -q "all tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: verification/cu_control_tb.sv
// Compute-unit control testbench
`default_nettype none

module cu_control_tb
	import cu_sizes_pkg::*;
	import cu_types_pkg::*;
();
	localparam int FILL_CYCLES = 10;
	localparam int RAND_CYCLES = 40;
	localparam int NUM_RSP     = 24;
	localparam int NUM_CMDS    = 2 * (FILL_CYCLES + RAND_CYCLES);
	localparam int CYCLE_LIMIT = 40 * NUM_CMDS + 200;
	localparam logic [63:0] CFG_WORD = 64'h0000_00a5_1234_0007;

	logic clock = 1'b0;
	logic rstn;
	logic enabled_in;
	logic [63:0] configure_word;
	logic wed_valid;
	logic [COUNT_BITS-1:0] wed_num_vertices;
	logic [COUNT_BITS-1:0] wed_num_edges;
	logic vertex_cmd_valid;
	cmd_opcode_t vertex_cmd_opcode;
	logic [TAG_BITS-1:0] vertex_cmd_tag;
	logic [ADDR_BITS-1:0] vertex_cmd_addr;
	logic vertex_cmd_ready;
	logic algorithm_cmd_valid;
	cmd_opcode_t algorithm_cmd_opcode;
	logic [TAG_BITS-1:0] algorithm_cmd_tag;
	logic [ADDR_BITS-1:0] algorithm_cmd_addr;
	logic algorithm_cmd_ready;
	logic read_command_out_valid;
	cmd_opcode_t read_command_out_opcode;
	cu_id_t read_command_out_cu_id;
	logic [TAG_BITS-1:0] read_command_out_tag;
	logic [ADDR_BITS-1:0] read_command_out_addr;
	logic read_buffer_alfull;
	logic read_response_valid;
	cu_id_t read_response_cu_id;
	logic [TAG_BITS-1:0] read_response_tag;
	logic vertex_response_valid;
	logic [TAG_BITS-1:0] vertex_response_tag;
	logic algorithm_response_valid;
	logic [TAG_BITS-1:0] algorithm_response_tag;
	logic cu_done;
	logic [COUNT_BITS-1:0] cu_return_vertices;
	logic [COUNT_BITS-1:0] cu_return_edges;
	logic [63:0] cu_status;

	integer seed = 32'h7d06;
	int cycles = 0;
	int alfull_run = 0;
	int after_alfull = 0;
	int run_len = 0;
	bit alternation_on = 0;
	cu_id_t last_src = CU_VERTEX;
	cmd_line_t vertex_q[$];
	cmd_line_t algorithm_q[$];
	rsp_line_t rsp_d0 = '0;
	rsp_line_t rsp_d1 = '0;

	cu_control_top u_cu_control_top (.*);

	always #20 clock = ~clock;

	function automatic cmd_line_t expected_line(cu_id_t id, cmd_opcode_t op,
		logic [TAG_BITS-1:0] tag, logic [ADDR_BITS-1:0] addr);
		cmd_line_t line;
		line.valid  = 1'b1;
		line.opcode = op;
		line.cu_id  = id;
		line.tag    = tag;
		line.addr   = addr;
		return line;
	endfunction

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic compare_cmd(input string name, input cmd_line_t got, input cmd_line_t exp);
		if (got !== exp) fail_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
	endtask

	task automatic compare_tag(input string name, input logic [TAG_BITS-1:0] got,
		input logic [TAG_BITS-1:0] exp);
		if (got !== exp) fail_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
	endtask

	task automatic compare_flag(input string name, input logic got, input logic exp);
		if (got !== exp) fail_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
	endtask

	task automatic compare_count(input string name, input logic [COUNT_BITS-1:0] got,
		input logic [COUNT_BITS-1:0] exp);
		if (got !== exp) fail_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
	endtask

	task automatic compare_status(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		if (got !== exp) fail_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
	endtask

	task automatic next_cycle();
		@(posedge clock);
		#5;
	endtask

	task automatic drive_cmds(input logic v_on, input logic a_on);
		vertex_cmd_valid     = v_on;
		vertex_cmd_opcode    = ($random(seed) & 1) ? CMD_READ_CL_S : CMD_READ_CL_NA;
		vertex_cmd_tag       = TAG_BITS'($random(seed));
		vertex_cmd_addr      = ADDR_BITS'($random(seed));
		algorithm_cmd_valid  = a_on;
		algorithm_cmd_opcode = ($random(seed) & 1) ? CMD_READ_CL_S : CMD_READ_CL_NA;
		algorithm_cmd_tag    = TAG_BITS'($random(seed));
		algorithm_cmd_addr   = ADDR_BITS'($random(seed));
	endtask

	////////////////////
	// Monitors
	////////////////////

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles > CYCLE_LIMIT) fail_run("timeout waiting for the DUT to finish");
		if (rstn && vertex_cmd_valid && vertex_cmd_ready)
			vertex_q.push_back(expected_line(CU_VERTEX, vertex_cmd_opcode,
				vertex_cmd_tag, vertex_cmd_addr));
		if (rstn && algorithm_cmd_valid && algorithm_cmd_ready)
			algorithm_q.push_back(expected_line(CU_ALGORITHM, algorithm_cmd_opcode,
				algorithm_cmd_tag, algorithm_cmd_addr));
		alfull_run <= read_buffer_alfull ? alfull_run + 1 : 0;
		rsp_d1 <= rsp_d0;
		rsp_d0 <= '{valid: read_response_valid, cu_id: read_response_cu_id,
			tag: read_response_tag};
	end

	// Compare on the falling edge where outputs are settled
	always @(negedge clock) begin
		cmd_line_t got;
		cmd_line_t exp;
		if (rstn && read_command_out_valid) begin
			got = '{valid: 1'b1, opcode: read_command_out_opcode, cu_id: read_command_out_cu_id,
				tag: read_command_out_tag, addr: read_command_out_addr};
			if (read_command_out_cu_id == CU_VERTEX) begin
				if (vertex_q.size() == 0) fail_run("vertex command out that was never sent");
				exp = vertex_q.pop_front();
			end else begin
				if (algorithm_q.size() == 0) fail_run("algorithm command out that was never sent");
				exp = algorithm_q.pop_front();
			end
			compare_cmd("read_command_out", got, exp);
			run_len = (read_command_out_cu_id == last_src) ? run_len + 1 : 1;
			last_src = read_command_out_cu_id;
			if (alternation_on && run_len >= 3 &&
				((last_src == CU_VERTEX) ? algorithm_q.size() : vertex_q.size()) != 0)
				fail_run("one source granted three times in a row while the other waited");
			after_alfull = (alfull_run > 0) ? after_alfull + 1 : 0;
			if (after_alfull > 2) fail_run("more than two commands issued after alfull");
		end else if (alfull_run == 0) begin
			after_alfull = 0;
		end
		if (rstn) begin
			compare_flag("vertex_response_valid", vertex_response_valid,
				rsp_d1.valid && rsp_d1.cu_id == CU_VERTEX);
			compare_flag("algorithm_response_valid", algorithm_response_valid,
				rsp_d1.valid && rsp_d1.cu_id == CU_ALGORITHM);
			if (rsp_d1.valid && rsp_d1.cu_id == CU_VERTEX)
				compare_tag("vertex_response_tag", vertex_response_tag, rsp_d1.tag);
			if (rsp_d1.valid && rsp_d1.cu_id == CU_ALGORITHM)
				compare_tag("algorithm_response_tag", algorithm_response_tag, rsp_d1.tag);
		end
	end

	////////////////////
	// Stimulus
	////////////////////

	initial begin
		int n_v;
		int n_e;
		rstn = 1'b0;
		enabled_in = 1'b0;
		configure_word = '0;
		wed_valid = 1'b0;
		wed_num_vertices = '0;
		wed_num_edges = '0;
		read_buffer_alfull = 1'b1;
		read_response_valid = 1'b0;
		read_response_cu_id = CU_VERTEX;
		read_response_tag = '0;
		drive_cmds(1'b0, 1'b0);
		repeat (8) next_cycle();

		// Nothing valid or ready while held in reset
		compare_flag("vertex_cmd_ready", vertex_cmd_ready, 1'b0);
		compare_flag("algorithm_cmd_ready", algorithm_cmd_ready, 1'b0);
		compare_flag("read_command_out_valid", read_command_out_valid, 1'b0);
		compare_flag("vertex_response_valid", vertex_response_valid, 1'b0);
		compare_flag("algorithm_response_valid", algorithm_response_valid, 1'b0);
		compare_flag("cu_done", cu_done, 1'b0);
		rstn = 1'b1;
		enabled_in = 1'b1;
		configure_word = CFG_WORD;
		next_cycle();
		compare_flag("vertex_cmd_ready", vertex_cmd_ready, 1'b1);
		compare_flag("algorithm_cmd_ready", algorithm_cmd_ready, 1'b1);
		configure_word = '0;
		next_cycle();

		// Fill both FIFOs behind alfull, then drain
		repeat (FILL_CYCLES) begin
			drive_cmds(1'b1, 1'b1);
			next_cycle();
		end
		drive_cmds(1'b0, 1'b0);
		if (vertex_q.size() != SRC_FIFO_DEPTH || algorithm_q.size() != SRC_FIFO_DEPTH)
			fail_run("source FIFOs did not take exactly their depth of commands");
		compare_flag("vertex_cmd_ready", vertex_cmd_ready, 1'b0);
		compare_flag("algorithm_cmd_ready", algorithm_cmd_ready, 1'b0);
		alternation_on = 1;
		read_buffer_alfull = 1'b0;
		repeat (6) next_cycle();
		// Memory side backs off in mid-drain
		read_buffer_alfull = 1'b1;
		repeat (6) next_cycle();
		read_buffer_alfull = 1'b0;
		while (vertex_q.size() != 0 || algorithm_q.size() != 0) next_cycle();
		alternation_on = 0;

		// Random traffic with alfull pulses
		repeat (RAND_CYCLES) begin
			drive_cmds(($random(seed) & 3) != 0, ($random(seed) & 1) != 0);
			read_buffer_alfull = ($random(seed) & 7) == 0;
			next_cycle();
		end
		drive_cmds(1'b0, 1'b0);
		read_buffer_alfull = 1'b0;
		while (vertex_q.size() != 0 || algorithm_q.size() != 0) next_cycle();

		// Responses against a descriptor worked out up front
		n_v = 0;
		n_e = 0;
		repeat (NUM_RSP) begin
			if ($random(seed) & 1) n_v++;
			else n_e++;
		end
		wed_valid = 1'b1;
		wed_num_vertices = COUNT_BITS'(n_v);
		wed_num_edges = COUNT_BITS'(n_e);
		next_cycle();
		wed_valid = 1'b0;
		for (int i = 0; i < n_v + n_e; i++) begin
			read_response_valid = 1'b1;
			read_response_cu_id = (i < n_v) ? CU_VERTEX : CU_ALGORITHM;
			read_response_tag = TAG_BITS'($random(seed));
			next_cycle();
		end
		read_response_valid = 1'b0;
		@(negedge clock);
		compare_flag("cu_done", cu_done, 1'b0);
		@(negedge clock);
		compare_flag("cu_done", cu_done, 1'b0);
		@(negedge clock);
		compare_flag("cu_done", cu_done, 1'b1);
		compare_count("cu_return_vertices", cu_return_vertices, COUNT_BITS'(n_v));
		compare_count("cu_return_edges", cu_return_edges, COUNT_BITS'(n_e));
		compare_status("cu_status", cu_status, CFG_WORD);
		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: verification/cu_control_properties.sv
// Compute-unit control assertions
`default_nettype none

module cu_control_properties (
	input wire clock,
	input wire rstn,
	input wire vertex_pop,
	input wire algorithm_pop,
	input wire vertex_empty,
	input wire algorithm_empty,
	input wire burst_push,
	input wire burst_full,
	input wire vertex_response_valid,
	input wire algorithm_response_valid
);

	// One grant per cycle
	single_pop: assert property (@(posedge clock) disable iff (!rstn)
		!(vertex_pop && algorithm_pop))
		else $error("both source FIFOs popped in one cycle");

	no_empty_pop: assert property (@(posedge clock) disable iff (!rstn)
		!(vertex_pop && vertex_empty) && !(algorithm_pop && algorithm_empty))
		else $error("pop of an empty source FIFO");

	// Arbiter headroom keeps the burst FIFO from overflowing
	no_full_push: assert property (@(posedge clock) disable iff (!rstn)
		!(burst_push && burst_full))
		else $error("push into a full burst FIFO");

	// Responses go to exactly one port
	one_route: assert property (@(posedge clock) disable iff (!rstn)
		!(vertex_response_valid && algorithm_response_valid))
		else $error("both routed response valids high");

endmodule

bind cu_control_top cu_control_properties u_cu_control_properties (
	.clock                   (clock),
	.rstn                    (rstn),
	.vertex_pop              (vertex_pop),
	.algorithm_pop           (algorithm_pop),
	.vertex_empty            (vertex_empty),
	.algorithm_empty         (algorithm_empty),
	.burst_push              (burst_push),
	.burst_full              (u_burst_fifo.full),
	.vertex_response_valid   (vertex_response_valid),
	.algorithm_response_valid(algorithm_response_valid)
);

`default_nettype wire

// File: rtl/cu_control_top.sv
// Compute-unit read control
`default_nettype none

module cu_control_top
	import cu_sizes_pkg::*;
	import cu_types_pkg::*;
(
	input  logic                  clock,
	input  logic                  rstn,
	input  logic                  enabled_in,
	input  logic [63:0]           configure_word,
	input  logic                  wed_valid,
	input  logic [COUNT_BITS-1:0] wed_num_vertices,
	input  logic [COUNT_BITS-1:0] wed_num_edges,
	input  logic                  vertex_cmd_valid,
	input  cmd_opcode_t           vertex_cmd_opcode,
	input  logic [TAG_BITS-1:0]   vertex_cmd_tag,
	input  logic [ADDR_BITS-1:0]  vertex_cmd_addr,
	output logic                  vertex_cmd_ready,
	input  logic                  algorithm_cmd_valid,
	input  cmd_opcode_t           algorithm_cmd_opcode,
	input  logic [TAG_BITS-1:0]   algorithm_cmd_tag,
	input  logic [ADDR_BITS-1:0]  algorithm_cmd_addr,
	output logic                  algorithm_cmd_ready,
	output logic                  read_command_out_valid,
	output cmd_opcode_t           read_command_out_opcode,
	output cu_id_t                read_command_out_cu_id,
	output logic [TAG_BITS-1:0]   read_command_out_tag,
	output logic [ADDR_BITS-1:0]  read_command_out_addr,
	input  logic                  read_buffer_alfull,
	input  logic                  read_response_valid,
	input  cu_id_t                read_response_cu_id,
	input  logic [TAG_BITS-1:0]   read_response_tag,
	output logic                  vertex_response_valid,
	output logic [TAG_BITS-1:0]   vertex_response_tag,
	output logic                  algorithm_response_valid,
	output logic [TAG_BITS-1:0]   algorithm_response_tag,
	output logic                  cu_done,
	output logic [COUNT_BITS-1:0] cu_return_vertices,
	output logic [COUNT_BITS-1:0] cu_return_edges,
	output logic [63:0]           cu_status
);
	logic                  enabled;
	cmd_line_t             vertex_line;
	cmd_line_t             algorithm_line;
	cmd_line_t             vertex_fifo_out;
	cmd_line_t             algorithm_fifo_out;
	logic                  vertex_push;
	logic                  algorithm_push;
	logic                  vertex_full;
	logic                  algorithm_full;
	logic                  vertex_empty;
	logic                  algorithm_empty;
	logic                  vertex_pop;
	logic                  algorithm_pop;
	logic                  vertex_pop_q;
	logic                  algorithm_pop_q;
	cmd_line_t             burst_in;
	logic                  burst_push;
	cmd_line_t             burst_out;
	logic                  burst_almost_full;
	logic                  burst_empty;
	logic                  burst_pop;
	logic                  burst_pop_q;
	cmd_line_t             read_cmd_q;
	logic [COUNT_BITS-1:0] vertex_count;
	logic [COUNT_BITS-1:0] algorithm_count;

	////////////////////
	// Source FIFOs
	////////////////////

	assign vertex_cmd_ready    = enabled && !vertex_full;
	assign algorithm_cmd_ready = enabled && !algorithm_full;
	assign vertex_push         = vertex_cmd_valid && vertex_cmd_ready;
	assign algorithm_push      = algorithm_cmd_valid && algorithm_cmd_ready;

	// Each source tags its lines with its own cu id
	assign vertex_line = '{valid: vertex_cmd_valid, opcode: vertex_cmd_opcode,
		cu_id: CU_VERTEX, tag: vertex_cmd_tag, addr: vertex_cmd_addr};
	assign algorithm_line = '{valid: algorithm_cmd_valid, opcode: algorithm_cmd_opcode,
		cu_id: CU_ALGORITHM, tag: algorithm_cmd_tag, addr: algorithm_cmd_addr};

	cmd_fifo #(
		.DEPTH(SRC_FIFO_DEPTH),
		.WIDTH(CMD_LINE_BITS)
	) u_vertex_fifo (
		.clock      (clock),
		.rstn       (rstn),
		.push       (vertex_push),
		.data_in    (vertex_line),
		.pop        (vertex_pop),
		.data_out   (vertex_fifo_out),
		.full       (vertex_full),
		.almost_full(),
		.empty      (vertex_empty)
	);

	cmd_fifo #(
		.DEPTH(SRC_FIFO_DEPTH),
		.WIDTH(CMD_LINE_BITS)
	) u_algorithm_fifo (
		.clock      (clock),
		.rstn       (rstn),
		.push       (algorithm_push),
		.data_in    (algorithm_line),
		.pop        (algorithm_pop),
		.data_out   (algorithm_fifo_out),
		.full       (algorithm_full),
		.almost_full(),
		.empty      (algorithm_empty)
	);

	////////////////////
	// Arbitration
	////////////////////

	read_cmd_arbiter u_read_cmd_arbiter (
		.clock             (clock),
		.rstn              (rstn),
		.enabled           (enabled),
		.vertex_empty      (vertex_empty),
		.algorithm_empty   (algorithm_empty),
		.burst_almost_full (burst_almost_full),
		.read_buffer_alfull(read_buffer_alfull),
		.vertex_pop        (vertex_pop),
		.algorithm_pop     (algorithm_pop)
	);

	// Popped line shows up a cycle after the grant
	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			vertex_pop_q    <= 1'b0;
			algorithm_pop_q <= 1'b0;
		end else begin
			vertex_pop_q    <= vertex_pop;
			algorithm_pop_q <= algorithm_pop;
		end
	end

	assign burst_push = vertex_pop_q || algorithm_pop_q;
	assign burst_in   = vertex_pop_q ? vertex_fifo_out : algorithm_fifo_out;

	////////////////////
	// Burst FIFO
	////////////////////

	assign burst_pop = enabled && !burst_empty && !read_buffer_alfull;

	cmd_fifo #(
		.DEPTH   (BURST_FIFO_DEPTH),
		.HEADROOM(BURST_HEADROOM),
		.WIDTH   (CMD_LINE_BITS)
	) u_burst_fifo (
		.clock      (clock),
		.rstn       (rstn),
		.push       (burst_push),
		.data_in    (burst_in),
		.pop        (burst_pop),
		.data_out   (burst_out),
		.full       (),
		.almost_full(burst_almost_full),
		.empty      (burst_empty)
	);

	// Read command output register
	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			burst_pop_q <= 1'b0;
			read_cmd_q  <= '0;
		end else if (enabled) begin
			burst_pop_q <= burst_pop;
			read_cmd_q  <= burst_pop_q ? burst_out : '0;
		end
	end

	assign read_command_out_valid  = read_cmd_q.valid;
	assign read_command_out_opcode = read_cmd_q.opcode;
	assign read_command_out_cu_id  = read_cmd_q.cu_id;
	assign read_command_out_tag    = read_cmd_q.tag;
	assign read_command_out_addr   = read_cmd_q.addr;

	////////////////////
	// Responses and completion
	////////////////////

	response_router u_response_router (
		.clock          (clock),
		.rstn           (rstn),
		.enabled        (enabled),
		.rsp_valid      (read_response_valid),
		.rsp_cu_id      (read_response_cu_id),
		.rsp_tag        (read_response_tag),
		.vertex_valid   (vertex_response_valid),
		.algorithm_valid(algorithm_response_valid),
		.vertex_tag     (vertex_response_tag),
		.algorithm_tag  (algorithm_response_tag),
		.vertex_count   (vertex_count),
		.algorithm_count(algorithm_count)
	);

	cu_config_regs u_cu_config_regs (
		.clock             (clock),
		.rstn              (rstn),
		.enabled_in        (enabled_in),
		.configure_word    (configure_word),
		.wed_valid         (wed_valid),
		.wed_num_vertices  (wed_num_vertices),
		.wed_num_edges     (wed_num_edges),
		.vertex_count      (vertex_count),
		.algorithm_count   (algorithm_count),
		.enabled           (enabled),
		.cu_done           (cu_done),
		.cu_return_vertices(cu_return_vertices),
		.cu_return_edges   (cu_return_edges),
		.cu_status         (cu_status)
	);

endmodule

`default_nettype wire

// File: rtl/cu_config_regs.sv
// Configuration, descriptor and completion
`default_nettype none

module cu_config_regs
	import cu_sizes_pkg::*;
(
	input  logic                  clock,
	input  logic                  rstn,
	input  logic                  enabled_in,
	input  logic [63:0]           configure_word,
	input  logic                  wed_valid,
	input  logic [COUNT_BITS-1:0] wed_num_vertices,
	input  logic [COUNT_BITS-1:0] wed_num_edges,
	input  logic [COUNT_BITS-1:0] vertex_count,
	input  logic [COUNT_BITS-1:0] algorithm_count,
	output logic                  enabled,
	output logic                  cu_done,
	output logic [COUNT_BITS-1:0] cu_return_vertices,
	output logic [COUNT_BITS-1:0] cu_return_edges,
	output logic [63:0]           cu_status
);
	logic [63:0]           configure_q;
	logic                  wed_held;
	logic [COUNT_BITS-1:0] wed_vertices;
	logic [COUNT_BITS-1:0] wed_edges;
	logic                  done_next;

	// Enable, configure word and descriptor flag
	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			enabled     <= 1'b0;
			configure_q <= '0;
			wed_held    <= 1'b0;
		end else begin
			enabled <= enabled_in;
			if (|configure_word) begin
				configure_q <= configure_word;
			end
			if (wed_valid) begin
				wed_held <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (wed_valid) begin
			wed_vertices <= wed_num_vertices;
			wed_edges    <= wed_num_edges;
		end
	end

	// Both sources must reach their descriptor count
	assign done_next = wed_held && (vertex_count == wed_vertices) &&
		(algorithm_count == wed_edges);

	////////////////////
	// Status outputs
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			cu_done            <= 1'b0;
			cu_return_vertices <= '0;
			cu_return_edges    <= '0;
			cu_status          <= '0;
		end else if (enabled) begin
			cu_done            <= done_next;
			cu_return_vertices <= wed_held ? vertex_count : '0;
			cu_return_edges    <= wed_held ? algorithm_count : '0;
			cu_status          <= configure_q;
		end
	end

endmodule

`default_nettype wire

// File: rtl/response_router.sv
// Read response router and counters
`default_nettype none

module response_router
	import cu_sizes_pkg::*;
	import cu_types_pkg::*;
(
	input  logic                  clock,
	input  logic                  rstn,
	input  logic                  enabled,
	input  logic                  rsp_valid,
	input  cu_id_t                rsp_cu_id,
	input  logic [TAG_BITS-1:0]   rsp_tag,
	output logic                  vertex_valid,
	output logic                  algorithm_valid,
	output logic [TAG_BITS-1:0]   vertex_tag,
	output logic [TAG_BITS-1:0]   algorithm_tag,
	output logic [COUNT_BITS-1:0] vertex_count,
	output logic [COUNT_BITS-1:0] algorithm_count
);
	rsp_line_t rsp_q;

	////////////////////
	// Input register
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			rsp_q <= '0;
		end else if (enabled) begin
			rsp_q.valid <= rsp_valid;
			rsp_q.cu_id <= rsp_cu_id;
			rsp_q.tag   <= rsp_tag;
		end
	end

	////////////////////
	// Steer by cu id
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			vertex_valid    <= 1'b0;
			algorithm_valid <= 1'b0;
			vertex_tag      <= '0;
			algorithm_tag   <= '0;
			vertex_count    <= '0;
			algorithm_count <= '0;
		end else if (enabled) begin
			vertex_valid    <= 1'b0;
			algorithm_valid <= 1'b0;
			vertex_tag      <= '0;
			algorithm_tag   <= '0;
			if (rsp_q.valid && rsp_q.cu_id == CU_VERTEX) begin
				vertex_valid <= 1'b1;
				vertex_tag   <= rsp_q.tag;
				vertex_count <= vertex_count + COUNT_BITS'(1);
			end else if (rsp_q.valid) begin
				algorithm_valid <= 1'b1;
				algorithm_tag   <= rsp_q.tag;
				algorithm_count <= algorithm_count + COUNT_BITS'(1);
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/read_cmd_arbiter.sv
// Round-robin read command arbiter
`default_nettype none

module read_cmd_arbiter
	import cu_types_pkg::*;
(
	input  logic clock,
	input  logic rstn,
	input  logic enabled,
	input  logic vertex_empty,
	input  logic algorithm_empty,
	input  logic burst_almost_full,
	input  logic read_buffer_alfull,
	output logic vertex_pop,
	output logic algorithm_pop
);
	arb_state_t last_grant;
	logic       can_issue;
	logic       vertex_req;
	logic       algorithm_req;

	// Memory side and burst FIFO both need room
	assign can_issue     = enabled && !read_buffer_alfull && !burst_almost_full;
	assign vertex_req    = can_issue && !vertex_empty;
	assign algorithm_req = can_issue && !algorithm_empty;

	always_comb begin
		vertex_pop    = 1'b0;
		algorithm_pop = 1'b0;
		if (vertex_req && algorithm_req) begin
			// Both waiting, so the other source goes
			if (last_grant == LAST_VERTEX) begin
				algorithm_pop = 1'b1;
			end else begin
				vertex_pop = 1'b1;
			end
		end else begin
			vertex_pop    = vertex_req;
			algorithm_pop = algorithm_req;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			last_grant <= LAST_ALGORITHM;
		end else if (vertex_pop) begin
			last_grant <= LAST_VERTEX;
		end else if (algorithm_pop) begin
			last_grant <= LAST_ALGORITHM;
		end
	end

endmodule

`default_nettype wire

// File: rtl/cmd_fifo.sv
// Synchronous command FIFO
`default_nettype none

module cmd_fifo
	import cu_sizes_pkg::*;
#(
	parameter int DEPTH    = SRC_FIFO_DEPTH,
	parameter int HEADROOM = 2,
	parameter int WIDTH    = CMD_LINE_BITS
) (
	input  logic             clock,
	input  logic             rstn,
	input  logic             push,
	input  logic [WIDTH-1:0] data_in,
	input  logic             pop,
	output logic [WIDTH-1:0] data_out,
	output logic             full,
	output logic             almost_full,
	output logic             empty
);
	localparam int PTR_BITS = $clog2(DEPTH);
	localparam int CNT_BITS = $clog2(DEPTH + 1);

	logic [WIDTH-1:0]    mem [DEPTH];
	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic [CNT_BITS-1:0] count;
	logic                do_push;
	logic                do_pop;

	// Overflow and underflow are dropped
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	assign full        = (count == CNT_BITS'(DEPTH));
	assign almost_full = (count >= CNT_BITS'(DEPTH - HEADROOM));
	assign empty       = (count == '0);

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + PTR_BITS'(1);
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + PTR_BITS'(1);
			end
			if (do_push && !do_pop) begin
				count <= count + CNT_BITS'(1);
			end else if (do_pop && !do_push) begin
				count <= count - CNT_BITS'(1);
			end
		end
	end

	// Storage and read register
	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= data_in;
		end
		if (do_pop) begin
			data_out <= mem[rd_ptr];
		end
	end

endmodule

`default_nettype wire

// File: rtl/cu_types_pkg.sv
// Compute-unit control data formats
`default_nettype none

package cu_types_pkg;
	import cu_sizes_pkg::*;

	// Source of a command or response
	typedef enum logic {
		CU_VERTEX    = 1'b0,
		CU_ALGORITHM = 1'b1
	} cu_id_t;

	// Read command kinds
	typedef enum logic [1:0] {
		CMD_READ_CL_NA = 2'b00,
		CMD_READ_CL_S  = 2'b01
	} cmd_opcode_t;

	// Last source granted by the read arbiter
	typedef enum logic {
		LAST_VERTEX    = 1'b0,
		LAST_ALGORITHM = 1'b1
	} arb_state_t;

	typedef struct packed {
		logic                 valid;
		cmd_opcode_t          opcode;
		cu_id_t               cu_id;
		logic [TAG_BITS-1:0]  tag;
		logic [ADDR_BITS-1:0] addr;
	} cmd_line_t;

	typedef struct packed {
		logic                valid;
		cu_id_t              cu_id;
		logic [TAG_BITS-1:0] tag;
	} rsp_line_t;

endpackage

`default_nettype wire

// File: rtl/cu_sizes_pkg.sv
// Compute-unit control sizing
`default_nettype none

package cu_sizes_pkg;

	////////////////////
	// Field widths
	////////////////////

	localparam int ADDR_BITS = 32;
	localparam int TAG_BITS = 8;
	localparam int COUNT_BITS = 32;

	// Valid, opcode, cu id, tag and address
	localparam int CMD_LINE_BITS = 1 + 2 + 1 + TAG_BITS + ADDR_BITS;

	////////////////////
	// Buffering
	////////////////////

	localparam int SRC_FIFO_DEPTH = 8;
	localparam int BURST_FIFO_DEPTH = 16;

	// Arbiter backs off once the burst FIFO holds this many lines
	localparam int BURST_HEADROOM = 8;

endpackage

`default_nettype wire
